//--- soc_pkg.sv
/*
  SoC bus fabric shared definitions.
  Widths, page-based address map, register indices, host packet
  framing, bus structs and the address region decoder.
*/
`default_nettype none

package soc_pkg;

  localparam int DATA_W       = 32;
  localparam int VADDR_W      = 17;
  localparam int PAGE_BITS    = 12;
  localparam int MAP_BITS     = 5;
  localparam int CODE_DEPTH   = 12;
  localparam int DATA_DEPTH   = 12;
  localparam int IO_REG_BITS  = 5;
  localparam int SYS_REG_BITS = 4;

  // system registers
  localparam int SYS_CPU_RESET  = 0;
  localparam int SYS_CPU_RESUME = 1;
  localparam int SYS_MASTER     = 2;

  localparam logic MASTER_IS_HOST = 1'b0;
  localparam logic MASTER_IS_CPU  = 1'b1;

  // io registers
  localparam int IO_W_LED         = 4;
  localparam int IO_W_TIMER_RESET = 15;
  localparam int IO_R_TIMER_COUNT = 4;

  // host packet is start byte, four addr bytes, four data bytes and end byte
  localparam logic [7:0] PKT_START = 8'hAA;
  localparam logic [7:0] PKT_END   = 8'h55;
  localparam int         PKT_LEN   = 10;

  typedef enum logic [3:0] {
    MAP_MEM_D = 4'd0,
    MAP_NONE  = 4'd1,
    MAP_REG_R = 4'd2,
    MAP_REG_W = 4'd3,
    MAP_MEM_I = 4'd4,
    MAP_SYS   = 4'd5
  } map_region_e;

  typedef enum logic [3:0] {
    PKT_IDLE,
    PKT_ADDR,
    PKT_DATA,
    PKT_TAIL
  } pkt_state_e;

  typedef struct packed {
    logic [31:0]       addr;
    logic [DATA_W-1:0] data;
    logic              we;
  } host_wr_t;

  typedef struct packed {
    logic [VADDR_W-1:0] addr_r_a;
    logic [VADDR_W-1:0] addr_r_b;
    logic [VADDR_W-1:0] addr_w;
    logic [DATA_W-1:0]  data_w;
    logic               we;
  } cpu_d_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data_a;
    logic [DATA_W-1:0] data_b;
  } cpu_d_rsp_t;

  typedef struct packed {
    logic [VADDR_W-1:0] addr;
    logic [DATA_W-1:0]  data;
    logic               we;
  } ram_wr_t;

  // unmapped pages fall to MAP_NONE
  function automatic map_region_e map_decode(input logic [VADDR_W-1:0] addr);
    logic [MAP_BITS-1:0] page;
    page = addr[VADDR_W-1:PAGE_BITS];
    case (page)
      5'd0:    return MAP_MEM_D;
      5'd2:    return MAP_REG_R;
      5'd3:    return MAP_REG_W;
      5'd4:    return MAP_MEM_I;
      5'd5:    return MAP_SYS;
      default: return MAP_NONE;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- simple_ram.sv
/*
  Simple dual-port RAM.
  One write port and one read port with a registered read,
  addressed by the low DEPTH bits.
*/
`timescale 1ns/100ps
`default_nettype none

module simple_ram #(
  parameter int DEPTH = 12
) (
  input  logic                           clk,
  input  soc_pkg::ram_wr_t               wr,
  input  logic [soc_pkg::VADDR_W-1:0]    addr_r,
  output logic [soc_pkg::DATA_W-1:0]     data_r
);

  logic [soc_pkg::DATA_W-1:0] mem [0:(2**DEPTH)-1];

  always_ff @(posedge clk)
  begin
    if (wr.we)
    begin
      mem[wr.addr[DEPTH-1:0]] <= wr.data;
    end
    data_r <= mem[addr_r[DEPTH-1:0]];
  end

endmodule

`default_nettype wire

//--- host_packet_rx.sv
/*
  Host packet receiver.
  Frames 10-byte packets from the serial receive byte stream and
  emits one host write per packet with good start and end bytes.
*/
`timescale 1ns/100ps
`default_nettype none

module host_packet_rx (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [7:0]        rx_data,
  input  logic              rx_ready,
  output soc_pkg::host_wr_t host_wr
);

  soc_pkg::pkt_state_e state_q;
  logic [3:0]          pos_q;
  logic                rx_ready_q;
  logic                rx_edge;
  logic [31:0]         addr_sh;
  logic [31:0]         data_sh;
  logic                pend_q;
  logic                wr_we_q;
  logic [31:0]         wr_addr_q;
  logic [31:0]         wr_data_q;

  assign rx_edge = rx_ready && !rx_ready_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rx_ready_q <= 1'b0;
    end
    else
    begin
      rx_ready_q <= rx_ready;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= soc_pkg::PKT_IDLE;
      pos_q   <= '0;
      pend_q  <= 1'b0;
    end
    else
    begin
      pend_q <= 1'b0;
      if (rx_edge)
      begin
        case (state_q)
          soc_pkg::PKT_IDLE:
          begin
            // wait for start byte
            if (rx_data == soc_pkg::PKT_START)
            begin
              state_q <= soc_pkg::PKT_ADDR;
              pos_q   <= 4'd1;
            end
          end
          soc_pkg::PKT_ADDR:
          begin
            pos_q <= pos_q + 4'd1;
            if (pos_q == 4'd4)
            begin
              state_q <= soc_pkg::PKT_DATA;
            end
          end
          soc_pkg::PKT_DATA:
          begin
            pos_q <= pos_q + 4'd1;
            if (pos_q == 4'(soc_pkg::PKT_LEN - 2))
            begin
              state_q <= soc_pkg::PKT_TAIL;
            end
          end
          default:
          begin
            // tenth byte, always back to idle
            state_q <= soc_pkg::PKT_IDLE;
            pos_q   <= '0;
            pend_q  <= (state_q == soc_pkg::PKT_TAIL) && (rx_data == soc_pkg::PKT_END);
          end
        endcase
      end
    end
  end

  // msb first
  always_ff @(posedge clk)
  begin
    if (rx_edge && (state_q == soc_pkg::PKT_ADDR))
    begin
      addr_sh <= {addr_sh[23:0], rx_data};
    end
    if (rx_edge && (state_q == soc_pkg::PKT_DATA))
    begin
      data_sh <= {data_sh[23:0], rx_data};
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_we_q <= 1'b0;
    end
    else
    begin
      wr_we_q <= pend_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pend_q)
    begin
      wr_addr_q <= addr_sh;
      wr_data_q <= data_sh;
    end
  end

  assign host_wr = '{addr: wr_addr_q, data: wr_data_q, we: wr_we_q};

endmodule

`default_nettype wire

//--- sys_regs.sv
/*
  System register file.
  Written by the host; bit 0 of each register drives processor
  reset, processor resume and the data-memory master select.
*/
`timescale 1ns/100ps
`default_nettype none

module sys_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             we,
  input  logic [soc_pkg::SYS_REG_BITS-1:0] index,
  input  logic [soc_pkg::DATA_W-1:0]       data,
  output logic                             cpu_reset,
  output logic                             cpu_resume,
  output logic                             master
);

  logic [soc_pkg::DATA_W-1:0] regs [0:(2**soc_pkg::SYS_REG_BITS)-1];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < (2**soc_pkg::SYS_REG_BITS); i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we)
    begin
      regs[index] <= data;
    end
  end

  assign cpu_reset  = regs[soc_pkg::SYS_CPU_RESET][0];
  assign cpu_resume = regs[soc_pkg::SYS_CPU_RESUME][0];
  // 0 host, 1 processor
  assign master     = regs[soc_pkg::SYS_MASTER][0];

endmodule

`default_nettype wire

//--- bus_switch.sv
/*
  Bus switch.
  Decodes host and processor addresses into map regions, routes the
  memory and register writes, and selects processor read data one
  cycle after the address to line up with the registered RAM read.
*/
`timescale 1ns/100ps
`default_nettype none

module bus_switch (
  input  logic                          clk,
  input  soc_pkg::host_wr_t             host_wr,
  input  soc_pkg::cpu_d_req_t           cpu_req,
  input  logic                          master,
  input  logic [soc_pkg::DATA_W-1:0]    mem_d_rd_a,
  input  logic [soc_pkg::DATA_W-1:0]    io_rd,
  output soc_pkg::ram_wr_t              mem_d_wr,
  output logic [soc_pkg::VADDR_W-1:0]   mem_d_addr_a,
  output soc_pkg::ram_wr_t              mem_i_wr,
  output logic                          sys_we,
  output logic                          io_we,
  output logic [soc_pkg::DATA_W-1:0]    data_a
);

  soc_pkg::map_region_e       host_region;
  soc_pkg::map_region_e       cpu_w_region;
  soc_pkg::map_region_e       cpu_ra_region;
  soc_pkg::map_region_e       ra_region_q;
  logic [soc_pkg::VADDR_W-1:0] host_addr;
  logic                       host_sel;
  logic                       cpu_sel;
  logic                       cpu_is_master;

  assign host_addr     = host_wr.addr[soc_pkg::VADDR_W-1:0];
  assign host_region   = soc_pkg::map_decode(host_addr);
  assign cpu_w_region  = soc_pkg::map_decode(cpu_req.addr_w);
  assign cpu_ra_region = soc_pkg::map_decode(cpu_req.addr_r_a);
  assign cpu_is_master = (master == soc_pkg::MASTER_IS_CPU);

  // data memory belongs to one master at a time
  assign host_sel = (master == soc_pkg::MASTER_IS_HOST) && (host_region == soc_pkg::MAP_MEM_D);
  assign cpu_sel  = cpu_is_master && (cpu_w_region == soc_pkg::MAP_MEM_D);

  always_comb
  begin
    if (host_sel)
    begin
      mem_d_wr = '{addr: host_addr, data: host_wr.data, we: host_wr.we};
    end
    else if (cpu_sel)
    begin
      mem_d_wr = '{addr: cpu_req.addr_w, data: cpu_req.data_w, we: cpu_req.we};
    end
    else
    begin
      mem_d_wr = '0;
    end
  end

  always_comb
  begin
    if (cpu_is_master && (cpu_ra_region == soc_pkg::MAP_MEM_D))
    begin
      mem_d_addr_a = cpu_req.addr_r_a;
    end
    else
    begin
      mem_d_addr_a = '0;
    end
  end

  // code memory is loaded by the host only
  assign mem_i_wr = '{
    addr: host_addr,
    data: host_wr.data,
    we:   host_wr.we && (host_region == soc_pkg::MAP_MEM_I)
  };

  assign sys_we = host_wr.we && (host_region == soc_pkg::MAP_SYS);
  assign io_we  = cpu_req.we && (cpu_w_region == soc_pkg::MAP_REG_W);

  always_ff @(posedge clk)
  begin
    ra_region_q <= cpu_ra_region;
  end

  // read data is one cycle behind its address
  always_comb
  begin
    if (cpu_is_master && (ra_region_q == soc_pkg::MAP_MEM_D))
    begin
      data_a = mem_d_rd_a;
    end
    else if (ra_region_q == soc_pkg::MAP_REG_R)
    begin
      data_a = io_rd;
    end
    else
    begin
      data_a = '0;
    end
  end

endmodule

`default_nettype wire

//--- io_regs.sv
/*
  I/O registers.
  Processor-written registers drive the LED and the timer hold;
  a free-running timer feeds the read registers.
*/
`timescale 1ns/100ps
`default_nettype none

module io_regs (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            we,
  input  logic [soc_pkg::IO_REG_BITS-1:0] addr_w,
  input  logic [soc_pkg::DATA_W-1:0]      data_w,
  input  logic [soc_pkg::IO_REG_BITS-1:0] addr_r,
  output logic [soc_pkg::DATA_W-1:0]      io_rd,
  output logic [9:0]                      led
);

  logic [soc_pkg::DATA_W-1:0] wr_regs [0:(2**soc_pkg::IO_REG_BITS)-1];
  logic [soc_pkg::DATA_W-1:0] rd_regs [0:(2**soc_pkg::IO_REG_BITS)-1];
  logic [soc_pkg::DATA_W-1:0] timer_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < (2**soc_pkg::IO_REG_BITS); i++)
      begin
        wr_regs[i] <= '0;
      end
      led <= '0;
    end
    else
    begin
      if (we)
      begin
        wr_regs[addr_w] <= data_w;
      end
      led <= wr_regs[soc_pkg::IO_W_LED][9:0];
    end
  end

  // held at zero while the hold bit is set
  always_ff @(posedge clk)
  begin
    if (!rst_n || wr_regs[soc_pkg::IO_W_TIMER_RESET][0])
    begin
      timer_q <= '0;
    end
    else
    begin
      timer_q <= timer_q + 1'b1;
    end
  end

  // two stages from timer to io_rd
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < (2**soc_pkg::IO_REG_BITS); i++)
    begin
      rd_regs[i] <= (i == soc_pkg::IO_R_TIMER_COUNT) ? timer_q : '0;
    end
    io_rd <= rd_regs[addr_r];
  end

endmodule

`default_nettype wire

//--- soc_top.sv
/*
  SoC bus fabric top level.
  Host packet loader, system and I/O registers, bus switch and the
  code and data memories; the processor sits outside on the cpu ports.
*/
`timescale 1ns/100ps
`default_nettype none

module soc_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [7:0]                       rx_data,
  input  logic                             rx_ready,
  input  soc_pkg::cpu_d_req_t              cpu_req,
  output soc_pkg::cpu_d_rsp_t              cpu_rsp,
  input  logic [soc_pkg::CODE_DEPTH-1:0]   cpu_i_addr,
  output logic [soc_pkg::DATA_W-1:0]       cpu_i_data,
  output logic                             cpu_reset,
  output logic                             cpu_resume,
  output logic [9:0]                       led
);

  soc_pkg::host_wr_t           host_wr;
  soc_pkg::ram_wr_t            mem_d_wr;
  soc_pkg::ram_wr_t            mem_i_wr;
  logic                        master;
  logic                        sys_we;
  logic                        io_we;
  logic [soc_pkg::VADDR_W-1:0] mem_d_addr_a;
  logic [soc_pkg::DATA_W-1:0]  mem_d_rd_a;
  logic [soc_pkg::DATA_W-1:0]  mem_d_rd_b;
  logic [soc_pkg::DATA_W-1:0]  io_rd;
  logic [soc_pkg::DATA_W-1:0]  data_a;

  wire [soc_pkg::VADDR_W-1:0] code_addr_r =
    {{(soc_pkg::VADDR_W - soc_pkg::CODE_DEPTH){1'b0}}, cpu_i_addr};

  host_packet_rx u_host_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_data  (rx_data),
    .rx_ready (rx_ready),
    .host_wr  (host_wr)
  );

  sys_regs u_sys_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .we         (sys_we),
    .index      (host_wr.addr[soc_pkg::SYS_REG_BITS-1:0]),
    .data       (host_wr.data),
    .cpu_reset  (cpu_reset),
    .cpu_resume (cpu_resume),
    .master     (master)
  );

  bus_switch u_bus_switch (
    .clk          (clk),
    .host_wr      (host_wr),
    .cpu_req      (cpu_req),
    .master       (master),
    .mem_d_rd_a   (mem_d_rd_a),
    .io_rd        (io_rd),
    .mem_d_wr     (mem_d_wr),
    .mem_d_addr_a (mem_d_addr_a),
    .mem_i_wr     (mem_i_wr),
    .sys_we       (sys_we),
    .io_we        (io_we),
    .data_a       (data_a)
  );

  io_regs u_io_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (io_we),
    .addr_w (cpu_req.addr_w[soc_pkg::IO_REG_BITS-1:0]),
    .data_w (cpu_req.data_w),
    .addr_r (cpu_req.addr_r_a[soc_pkg::IO_REG_BITS-1:0]),
    .io_rd  (io_rd),
    .led    (led)
  );

  simple_ram #(.DEPTH(soc_pkg::CODE_DEPTH)) mem_i (
    .clk    (clk),
    .wr     (mem_i_wr),
    .addr_r (code_addr_r),
    .data_r (cpu_i_data)
  );

  // data memory as two copies sharing the write port
  simple_ram #(.DEPTH(soc_pkg::DATA_DEPTH)) mem_d_a (
    .clk    (clk),
    .wr     (mem_d_wr),
    .addr_r (mem_d_addr_a),
    .data_r (mem_d_rd_a)
  );

  simple_ram #(.DEPTH(soc_pkg::DATA_DEPTH)) mem_d_b (
    .clk    (clk),
    .wr     (mem_d_wr),
    .addr_r (cpu_req.addr_r_b),
    .data_r (mem_d_rd_b)
  );

  assign cpu_rsp = '{data_a: data_a, data_b: mem_d_rd_b};

endmodule

`default_nettype wire

//--- soc_checker.sv
/*
  Bus fabric checker.
  Concurrent assertions on the host write strobe, the processor
  control outputs after reset and data-memory write ownership.
*/
`timescale 1ns/100ps
`default_nettype none

module soc_checker (
  input logic                clk,
  input logic                rst_n,
  input soc_pkg::host_wr_t   host_wr,
  input soc_pkg::cpu_d_req_t cpu_req,
  input soc_pkg::ram_wr_t    mem_d_wr,
  input logic                master,
  input logic                cpu_reset,
  input logic                cpu_resume
);

  logic assert_failed = 1'b0;
  logic host_owns;
  logic cpu_owns;

  assign host_owns = (master == soc_pkg::MASTER_IS_HOST) && host_wr.we
    && (soc_pkg::map_decode(host_wr.addr[soc_pkg::VADDR_W-1:0]) == soc_pkg::MAP_MEM_D);
  assign cpu_owns  = (master == soc_pkg::MASTER_IS_CPU) && cpu_req.we
    && (soc_pkg::map_decode(cpu_req.addr_w) == soc_pkg::MAP_MEM_D);

  host_we_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    host_wr.we |=> !host_wr.we)
  else
  begin
    $error("host write strobe high for two cycles");
    assert_failed = 1'b1;
  end

  ctrl_low_after_reset: assert property (@(posedge clk)
    !rst_n |=> (!cpu_reset && !cpu_resume))
  else
  begin
    $error("processor reset or resume high after reset");
    assert_failed = 1'b1;
  end

  // write enable only from the master that owns the data memory
  mem_d_owner: assert property (@(posedge clk) disable iff (!rst_n)
    mem_d_wr.we |-> (host_owns || cpu_owns))
  else
  begin
    $error("data memory written by a master that does not own it");
    assert_failed = 1'b1;
  end

endmodule

bind soc_top soc_checker chk0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .host_wr    (host_wr),
  .cpu_req    (cpu_req),
  .mem_d_wr   (mem_d_wr),
  .master     (master),
  .cpu_reset  (cpu_reset),
  .cpu_resume (cpu_resume)
);

`default_nettype wire

//--- tb_soc.sv
/*
  SoC bus fabric testbench.
  Plays the host over the serial byte port and the processor on the
  cpu buses, applying a table of steps and checking the responses.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_soc;

  localparam int TIMEOUT_CYCLES = 3000;
  localparam int MAX_STEPS      = 64;

  typedef enum logic [3:0] {
    OP_PKT,
    OP_PKT_BAD_START,
    OP_PKT_BAD_END,
    OP_WR,
    OP_RD_A,
    OP_RD_A_INC,
    OP_RD_B,
    OP_RD_I,
    OP_CHK_RESET,
    OP_CHK_RESUME,
    OP_CHK_LED,
    OP_WAIT
  } step_kind_e;

  typedef struct packed {
    logic [95:0] name;
    step_kind_e  kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
  } step_t;

  logic                                clk;
  logic                                rst_n;
  logic [7:0]                          rx_data;
  logic                                rx_ready;
  soc_pkg::cpu_d_req_t                 cpu_req;
  soc_pkg::cpu_d_rsp_t                 cpu_rsp;
  logic [soc_pkg::CODE_DEPTH-1:0]      cpu_i_addr;
  logic [soc_pkg::DATA_W-1:0]          cpu_i_data;
  logic                                cpu_reset;
  logic                                cpu_resume;
  logic [9:0]                          led;

  step_t       steps [0:MAX_STEPS-1];
  int          n_steps;
  int          cycles;
  logic        model_master;
  logic [31:0] last_a;

  soc_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_data    (rx_data),
    .rx_ready   (rx_ready),
    .cpu_req    (cpu_req),
    .cpu_rsp    (cpu_rsp),
    .cpu_i_addr (cpu_i_addr),
    .cpu_i_data (cpu_i_data),
    .cpu_reset  (cpu_reset),
    .cpu_resume (cpu_resume),
    .led        (led)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the test did not complete", cycles);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
    else if (dut0.chk0.assert_failed)
    begin
      $display("a bus assertion failed during the run");
      $display("** FAIL **");
      $fatal(1, "assertion failure");
    end
  end

  task add_step(input logic [95:0] name, input step_kind_e kind, input logic [31:0] addr,
                input logic [31:0] data, input logic [31:0] exp);
    steps[n_steps] = '{name: name, kind: kind, addr: addr, data: data, exp: exp};
    n_steps++;
  endtask

  task check_word(input logic [95:0] name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "value check failed");
    end
  endtask

  // one byte per rising edge of rx_ready
  task send_byte(input logic [7:0] b);
    @(posedge clk);
    rx_data  <= b;
    rx_ready <= 1'b1;
    @(posedge clk);
    rx_ready <= 1'b0;
  endtask

  task send_packet(input logic [7:0] first, input logic [31:0] addr, input logic [31:0] data,
                   input logic [7:0] last);
    send_byte(first);
    for (int k = 3; k >= 0; k--)
    begin
      send_byte(addr[8*k +: 8]);
    end
    for (int k = 3; k >= 0; k--)
    begin
      send_byte(data[8*k +: 8]);
    end
    send_byte(last);
    // host write lands two clocks after the last byte
    repeat (3) @(posedge clk);
  endtask

  task cpu_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    cpu_req.addr_w <= addr[soc_pkg::VADDR_W-1:0];
    cpu_req.data_w <= data;
    cpu_req.we     <= 1'b1;
    @(posedge clk);
    cpu_req.we     <= 1'b0;
  endtask

  task read_port_a(input logic [31:0] addr, output logic [31:0] value);
    @(posedge clk);
    cpu_req.addr_r_a <= addr[soc_pkg::VADDR_W-1:0];
    @(posedge clk);
    @(negedge clk);
    value = cpu_rsp.data_a;
  endtask

  task read_port_b(input logic [31:0] addr, output logic [31:0] value);
    @(posedge clk);
    cpu_req.addr_r_b <= addr[soc_pkg::VADDR_W-1:0];
    @(posedge clk);
    @(negedge clk);
    value = cpu_rsp.data_b;
  endtask

  task read_port_i(input logic [31:0] addr, output logic [31:0] value);
    @(posedge clk);
    cpu_i_addr <= addr[soc_pkg::CODE_DEPTH-1:0];
    @(posedge clk);
    @(negedge clk);
    value = cpu_i_data;
  endtask

  // port a shows memory only to the processor master, io reads always
  function automatic logic [31:0] expect_port_a(input logic [31:0] addr, input logic [31:0] word);
    case (soc_pkg::map_decode(addr[soc_pkg::VADDR_W-1:0]))
      soc_pkg::MAP_MEM_D: return (model_master == soc_pkg::MASTER_IS_CPU) ? word : 32'h0;
      soc_pkg::MAP_REG_R: return word;
      default:            return 32'h0;
    endcase
  endfunction

  task build_table;
    add_step("badstart_sys", OP_PKT_BAD_START, 32'h5000, 32'h1, 32'h0);
    add_step("reset_low",    OP_CHK_RESET,     32'h0,    32'h0, 32'h0);
    add_step("fill_d20",     OP_PKT,           32'h0020, 32'h11223344, 32'h0);
    add_step("read_d20",     OP_RD_B,          32'h0020, 32'h0, 32'h11223344);
    add_step("badend_d20",   OP_PKT_BAD_END,   32'h0020, 32'h55667788, 32'h0);
    add_step("keep_d20",     OP_RD_B,          32'h0020, 32'h0, 32'h11223344);
    add_step("badstart_d20", OP_PKT_BAD_START, 32'h0020, 32'h01020304, 32'h0);
    add_step("still_d20",    OP_RD_B,          32'h0020, 32'h0, 32'h11223344);
    add_step("set_reset",    OP_PKT,           32'h5000, 32'h1, 32'h0);
    add_step("reset_high",   OP_CHK_RESET,     32'h0,    32'h0, 32'h1);
    add_step("set_resume",   OP_PKT,           32'h5001, 32'h1, 32'h0);
    add_step("resume_high",  OP_CHK_RESUME,    32'h0,    32'h0, 32'h1);
    add_step("clr_reset",    OP_PKT,           32'h5000, 32'h0, 32'h0);
    add_step("reset_clear",  OP_CHK_RESET,     32'h0,    32'h0, 32'h0);
    add_step("resume_kept",  OP_CHK_RESUME,    32'h0,    32'h0, 32'h1);
    add_step("clr_resume",   OP_PKT,           32'h5001, 32'h2, 32'h0);
    add_step("resume_clear", OP_CHK_RESUME,    32'h0,    32'h0, 32'h0);
    add_step("code_3",       OP_PKT,           32'h4003, 32'hC0DE0003, 32'h0);
    add_step("code_7",       OP_PKT,           32'h4007, 32'hC0DE0007, 32'h0);
    add_step("fetch_3",      OP_RD_I,          32'h4003, 32'h0, 32'hC0DE0003);
    add_step("fetch_7",      OP_RD_I,          32'h4007, 32'h0, 32'hC0DE0007);
    add_step("host_d10",     OP_PKT,           32'h0010, 32'hD0D00010, 32'h0);
    add_step("host_d11",     OP_PKT,           32'h0011, 32'hD0D00011, 32'h0);
    add_step("cpu_wr_drop",  OP_WR,            32'h0010, 32'hBAD00010, 32'h0);
    add_step("a_hidden",     OP_RD_A,          32'h0010, 32'h0, 32'hD0D00010);
    add_step("b_d10",        OP_RD_B,          32'h0010, 32'h0, 32'hD0D00010);
    add_step("b_d11",        OP_RD_B,          32'h0011, 32'h0, 32'hD0D00011);
    add_step("master_cpu",   OP_PKT,           32'h5002, 32'h1, 32'h0);
    add_step("cpu_wr_d11",   OP_WR,            32'h0011, 32'hC0C00011, 32'h0);
    add_step("a_d11",        OP_RD_A,          32'h0011, 32'h0, 32'hC0C00011);
    add_step("b_d11_cpu",    OP_RD_B,          32'h0011, 32'h0, 32'hC0C00011);
    add_step("a_d10",        OP_RD_A,          32'h0010, 32'h0, 32'hD0D00010);
    add_step("led_write",    OP_WR,            32'h3004, 32'h00ABC3A5, 32'h0);
    add_step("led_value",    OP_CHK_LED,       32'h0,    32'h0, 32'h3A5);
    add_step("timer_hold",   OP_WR,            32'h300F, 32'h1, 32'h0);
    add_step("hold_settle",  OP_WAIT,          32'h0,    32'd4, 32'h0);
    add_step("timer_zero",   OP_RD_A,          32'h2004, 32'h0, 32'h0);
    add_step("timer_run",    OP_WR,            32'h300F, 32'h0, 32'h0);
    add_step("run_settle",   OP_WAIT,          32'h0,    32'd3, 32'h0);
    add_step("timer_up_1",   OP_RD_A_INC,      32'h2004, 32'h0, 32'h0);
    add_step("timer_up_2",   OP_RD_A_INC,      32'h2004, 32'h0, 32'h0);
    add_step("regw_read",    OP_RD_A,          32'h3004, 32'h0, 32'h3A5);
  endtask

  initial
  begin : run
    logic [31:0] value;
    logic [7:0]  corrupt;
    clk          = 1'b0;
    rst_n        = 1'b0;
    rx_data      = 8'h00;
    rx_ready     = 1'b0;
    cpu_req      = '0;
    cpu_i_addr   = '0;
    cycles       = 0;
    n_steps      = 0;
    model_master = soc_pkg::MASTER_IS_HOST;
    last_a       = 32'h0;
    void'($urandom(32'h253d4cf4));
    build_table();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_steps; i++)
    begin
      corrupt = 8'($urandom_range(255, 1));
      case (steps[i].kind)
        OP_PKT:
        begin
          send_packet(soc_pkg::PKT_START, steps[i].addr, steps[i].data, soc_pkg::PKT_END);
          if ((soc_pkg::map_decode(steps[i].addr[soc_pkg::VADDR_W-1:0]) == soc_pkg::MAP_SYS)
              && (steps[i].addr[soc_pkg::SYS_REG_BITS-1:0] == soc_pkg::SYS_MASTER))
          begin
            model_master = steps[i].data[0];
          end
        end
        OP_PKT_BAD_START:
          send_packet(soc_pkg::PKT_START ^ corrupt, steps[i].addr, steps[i].data,
                      soc_pkg::PKT_END);
        OP_PKT_BAD_END:
          send_packet(soc_pkg::PKT_START, steps[i].addr, steps[i].data,
                      soc_pkg::PKT_END ^ corrupt);
        OP_WR:
          cpu_write(steps[i].addr, steps[i].data);
        OP_RD_A:
        begin
          read_port_a(steps[i].addr, value);
          check_word(steps[i].name, expect_port_a(steps[i].addr, steps[i].exp), value);
          last_a = value;
        end
        OP_RD_A_INC:
        begin
          read_port_a(steps[i].addr, value);
          assert (value > last_a)
          else
          begin
            $display("timer count did not increase in %s: previous %h, now %h",
                     steps[i].name, last_a, value);
            $display("** FAIL **");
            $fatal(1, "timer check failed");
          end
          last_a = value;
        end
        OP_RD_B:
        begin
          read_port_b(steps[i].addr, value);
          check_word(steps[i].name, steps[i].exp, value);
        end
        OP_RD_I:
        begin
          read_port_i(steps[i].addr, value);
          check_word(steps[i].name, steps[i].exp, value);
        end
        OP_CHK_RESET:
        begin
          @(posedge clk);
          @(negedge clk);
          check_word(steps[i].name, steps[i].exp, {31'b0, cpu_reset});
        end
        OP_CHK_RESUME:
        begin
          @(posedge clk);
          @(negedge clk);
          check_word(steps[i].name, steps[i].exp, {31'b0, cpu_resume});
        end
        OP_CHK_LED:
        begin
          @(posedge clk);
          @(negedge clk);
          check_word(steps[i].name, steps[i].exp, {22'b0, led});
        end
        default:
          repeat (steps[i].data) @(posedge clk);
      endcase
    end
    repeat (2) @(posedge clk);
    if (dut0.chk0.assert_failed)
    begin
      $display("a bus assertion failed during the run");
      $display("** FAIL **");
      $fatal(1, "assertion failure");
    end
    else
    begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- compile.f
soc_pkg.sv
simple_ram.sv
host_packet_rx.sv
sys_regs.sv
bus_switch.sv
io_regs.sv
soc_top.sv
soc_checker.sv
tb_soc.sv
